/* grabber_settings.svh */
`ifndef GRABBER_SETTINGS_SVH
`define GRABBER_SETTINGS_SVH

// Camera byte and stream word
`define GRB_PIX_W           8
`define GRB_WORD_W          32
`define GRB_BYTES_PER_WORD  4

// Capture FIFO, pointer width is log2 of the depth
`define GRB_FIFO_DEPTH      512
`define GRB_FIFO_AW         9

// Sensor clock divider, top bit drives XCLK
`define GRB_XCLK_DIV_W      2

// Register bank
`define GRB_LITE_WORDS      32
`define GRB_LITE_IDX_W      5
`define GRB_LITE_ADDR_W     32

`endif

/* cam_pkg.sv */
`include "grabber_settings.svh"

package cam_pkg;

  // One sensor byte
  typedef logic [`GRB_PIX_W-1:0] pix_t;

  // Four packed bytes, byte 0 in the low bits
  typedef logic [`GRB_WORD_W-1:0] stream_word_t;

  // Byte slot inside a stream word
  typedef logic [1:0] byte_pos_t;

  typedef enum logic
  {
    CAP_WAIT_FRAME,
    CAP_RUN
  } cap_state_t;

endpackage

/* lite_pkg.sv */
`include "grabber_settings.svh"

package lite_pkg;

  typedef logic [`GRB_LITE_ADDR_W-1:0] lite_addr_t;
  typedef logic [`GRB_WORD_W-1:0] lite_data_t;
  typedef logic [`GRB_BYTES_PER_WORD-1:0] lite_strb_t;

  // Word index, taken from address bits 6..2
  typedef logic [`GRB_LITE_IDX_W-1:0] lite_idx_t;

  typedef logic [`GRB_PIX_W-1:0] lite_byte_t;

endpackage

/* cam_input_sync.sv */
`timescale 1ns/1ps
`include "grabber_settings.svh"

module cam_input_sync import cam_pkg::*;
(
  input  logic bus_clk,
  input  logic rst_n_i,
  input  pix_t cam_d_i,
  input  logic cam_pclk_i,
  input  logic cam_hsync_i,
  input  logic cam_vsync_i,
  output logic cam_xclk_o,
  output pix_t pix_o,
  output logic hsync_o,
  output logic vsync_o,
  output logic pclk_rise_o
);

  pix_t d_guard_q;
  pix_t d_sync_q;
  logic pclk_guard_q, pclk_sync_q, pclk_prev_q;
  logic hsync_guard_q, hsync_sync_q;
  logic vsync_guard_q, vsync_sync_q;
  logic pclk_rise_q;
  logic [`GRB_XCLK_DIV_W-1:0] div_q;

  // Pixel byte guard stages
  always_ff @(posedge bus_clk)
  begin
    d_guard_q <= cam_d_i;
    d_sync_q  <= d_guard_q;
  end

  // Two-stage guards on the control pads plus edge detect
  always_ff @(posedge bus_clk)
  begin
    if (!rst_n_i)
    begin
      pclk_guard_q  <= 1'b0;
      pclk_sync_q   <= 1'b0;
      pclk_prev_q   <= 1'b0;
      hsync_guard_q <= 1'b0;
      hsync_sync_q  <= 1'b0;
      vsync_guard_q <= 1'b0;
      vsync_sync_q  <= 1'b0;
      pclk_rise_q   <= 1'b0;
    end
    else
    begin
      pclk_guard_q  <= cam_pclk_i;
      pclk_sync_q   <= pclk_guard_q;
      pclk_prev_q   <= pclk_sync_q;
      hsync_guard_q <= cam_hsync_i;
      hsync_sync_q  <= hsync_guard_q;
      vsync_guard_q <= cam_vsync_i;
      vsync_sync_q  <= vsync_guard_q;
      pclk_rise_q   <= pclk_sync_q && !pclk_prev_q;
    end
  end

  // Free-running divider for the sensor master clock
  always_ff @(posedge bus_clk)
  begin
    if (!rst_n_i)
      div_q <= '0;
    else
      div_q <= div_q + 1'b1;
  end

  assign cam_xclk_o  = div_q[`GRB_XCLK_DIV_W-1];
  assign pix_o       = d_sync_q;
  assign hsync_o     = hsync_sync_q;
  assign vsync_o     = vsync_sync_q;
  assign pclk_rise_o = pclk_rise_q;

endmodule

/* cam_word_packer.sv */
`timescale 1ns/1ps
`include "grabber_settings.svh"

module cam_word_packer import cam_pkg::*;
(
  input  logic         bus_clk,
  input  logic         rst_n_i,
  input  logic         rd32_open_i,
  input  pix_t         pix_i,
  input  logic         hsync_i,
  input  logic         vsync_i,
  input  logic         pclk_rise_i,
  output stream_word_t word_o,
  output logic         word_stb_o
);

  localparam byte_pos_t LAST_POS = byte_pos_t'(`GRB_BYTES_PER_WORD - 1);

  cap_state_t   state_q;
  byte_pos_t    byte_pos_q;
  stream_word_t word_q;
  logic         word_stb_q;
  logic         take_byte;

  // A valid pixel byte while running and inside a line
  assign take_byte = (state_q == CAP_RUN) && pclk_rise_i && hsync_i;

  always_ff @(posedge bus_clk)
  begin
    if (!rst_n_i || !rd32_open_i)
    begin
      state_q    <= CAP_WAIT_FRAME;
      byte_pos_q <= '0;
      word_stb_q <= 1'b0;
    end
    else
    begin
      word_stb_q <= 1'b0;
      case (state_q)
        CAP_WAIT_FRAME:
        begin
          byte_pos_q <= '0;
          // Start on the first pixel edge seen with vsync high
          if (pclk_rise_i && vsync_i)
            state_q <= CAP_RUN;
        end
        CAP_RUN:
        begin
          if (take_byte)
          begin
            byte_pos_q <= byte_pos_q + 1'b1;
            if (byte_pos_q == LAST_POS)
              word_stb_q <= 1'b1;
          end
        end
        default:
          state_q <= CAP_WAIT_FRAME;
      endcase
    end
  end

  // Byte 0 lands in the low bits
  always_ff @(posedge bus_clk)
  begin
    if (take_byte)
      word_q[byte_pos_q*`GRB_PIX_W +: `GRB_PIX_W] <= pix_i;
  end

  assign word_o     = word_q;
  assign word_stb_o = word_stb_q;

  a_no_stb_waiting: assert property (@(posedge bus_clk) disable iff (!rst_n_i)
    (state_q == CAP_WAIT_FRAME) |-> !word_stb_o)
    else $error("word strobe while waiting for a frame");

endmodule

/* cam_stream_fifo.sv */
`timescale 1ns/1ps
`include "grabber_settings.svh"

module cam_stream_fifo import cam_pkg::*;
(
  input  logic         bus_clk,
  input  logic         rst_n_i,
  input  logic         rd32_open_i,
  input  stream_word_t word_i,
  input  logic         word_stb_i,
  input  logic         rd32_rden_i,
  output stream_word_t rd32_data_o,
  output logic         rd32_empty_o,
  output logic         rd32_eof_o
);

  localparam logic [`GRB_FIFO_AW:0] DEPTH_CNT = `GRB_FIFO_DEPTH;

  stream_word_t mem_q [`GRB_FIFO_DEPTH];
  logic [`GRB_FIFO_AW-1:0] wr_ptr_q;
  logic [`GRB_FIFO_AW-1:0] rd_ptr_q;
  logic [`GRB_FIFO_AW:0]   count_q;
  logic full;
  logic wr_ok;
  logic rd_ok;
  logic been_nonfull_q;
  logic been_full_q;

  assign full         = (count_q == DEPTH_CNT);
  assign rd32_empty_o = (count_q == '0);

  // Once the FIFO has filled up, nothing more goes in until close
  assign wr_ok = rd32_open_i && word_stb_i && !full && !been_full_q;
  assign rd_ok = rd32_open_i && rd32_rden_i && !rd32_empty_o;

  assign rd32_eof_o = been_full_q && rd32_empty_o;

  always_ff @(posedge bus_clk)
  begin
    if (wr_ok)
      mem_q[wr_ptr_q] <= word_i;
    if (rd_ok)
      rd32_data_o <= mem_q[rd_ptr_q];
  end

  // Closing the stream flushes the contents
  always_ff @(posedge bus_clk)
  begin
    if (!rst_n_i || !rd32_open_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_ok)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_ok)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Stop latch, armed only after a non-full cycle has been seen
  always_ff @(posedge bus_clk)
  begin
    if (!rst_n_i)
    begin
      been_nonfull_q <= 1'b0;
      been_full_q    <= 1'b0;
    end
    else
    begin
      if (!full)
        been_nonfull_q <= 1'b1;
      else if (!rd32_open_i)
        been_nonfull_q <= 1'b0;

      if (!rd32_open_i)
        been_full_q <= 1'b0;
      else if (full && been_nonfull_q)
        been_full_q <= 1'b1;
    end
  end

  a_count_bound: assert property (@(posedge bus_clk) disable iff (!rst_n_i)
    count_q <= DEPTH_CNT)
    else $error("FIFO count above depth");

  a_empty_read: assert property (@(posedge bus_clk) disable iff (!rst_n_i)
    rd32_rden_i && rd32_empty_o && rd32_open_i |=> $stable(rd_ptr_q) && $stable(rd32_data_o))
    else $error("read from empty FIFO changed state");

endmodule

/* lite_addr_decode.sv */
`timescale 1ns/1ps
`include "grabber_settings.svh"

module lite_addr_decode import lite_pkg::*;
(
  input  logic       bus_clk,
  input  logic       rst_n_i,
  input  lite_addr_t lite_addr_i,
  input  logic       lite_wren_i,
  input  logic       lite_rden_i,
  input  lite_strb_t lite_wstrb_i,
  output lite_idx_t  lane_idx_o,
  output lite_strb_t lane_we_o
);

  // Byte address to word index
  assign lane_idx_o = lite_addr_i[`GRB_LITE_IDX_W+1:2];

  // One write enable per byte lane
  assign lane_we_o = lite_wstrb_i & {`GRB_BYTES_PER_WORD{lite_wren_i}};

  a_word_aligned: assert property (@(posedge bus_clk) disable iff (!rst_n_i)
    (lite_wren_i || lite_rden_i) |-> (lite_addr_i[1:0] == 2'b00))
    else $error("unaligned register access");

endmodule

/* lite_byte_lane.sv */
`timescale 1ns/1ps
`include "grabber_settings.svh"

module lite_byte_lane import lite_pkg::*;
(
  input  logic       bus_clk,
  input  lite_idx_t  lane_idx_i,
  input  logic       lane_we_i,
  input  lite_byte_t wr_byte_i,
  output lite_byte_t rd_byte_o
);

  lite_byte_t mem_q [`GRB_LITE_WORDS];

  always_ff @(posedge bus_clk)
  begin
    if (lane_we_i)
      mem_q[lane_idx_i] <= wr_byte_i;
  end

  // Asynchronous read, registered later in the capture stage
  assign rd_byte_o = mem_q[lane_idx_i];

endmodule

/* lite_read_capture.sv */
`timescale 1ns/1ps
`include "grabber_settings.svh"

module lite_read_capture import lite_pkg::*;
(
  input  logic                                   bus_clk,
  input  logic                                   rst_n_i,
  input  logic                                   lite_rden_i,
  input  lite_byte_t [`GRB_BYTES_PER_WORD-1:0]   lane_bytes_i,
  output lite_data_t                             lite_rd_data_o
);

  // Lane 3 sits in the top byte of the packed array
  always_ff @(posedge bus_clk)
  begin
    if (!rst_n_i)
      lite_rd_data_o <= '0;
    else if (lite_rden_i)
      lite_rd_data_o <= lane_bytes_i;
  end

endmodule

/* grabber_top.sv */
`timescale 1ns/1ps
`include "grabber_settings.svh"

module grabber_top import cam_pkg::*, lite_pkg::*;
(
  input  logic         bus_clk,
  input  logic         rst_n_i,
  input  pix_t         cam_d_i,
  input  logic         cam_pclk_i,
  input  logic         cam_hsync_i,
  input  logic         cam_vsync_i,
  output logic         cam_xclk_o,
  input  logic         rd32_open_i,
  input  logic         rd32_rden_i,
  output stream_word_t rd32_data_o,
  output logic         rd32_empty_o,
  output logic         rd32_eof_o,
  input  lite_addr_t   lite_addr_i,
  input  logic         lite_wren_i,
  input  lite_strb_t   lite_wstrb_i,
  input  lite_data_t   lite_wr_data_i,
  input  logic         lite_rden_i,
  output lite_data_t   lite_rd_data_o
);

  pix_t         pix;
  logic         hsync;
  logic         vsync;
  logic         pclk_rise;
  stream_word_t word;
  logic         word_stb;

  lite_idx_t    lane_idx;
  lite_strb_t   lane_we;
  lite_byte_t [`GRB_BYTES_PER_WORD-1:0] lane_bytes;

  // Camera capture path
  cam_input_sync u_input_sync (
    .bus_clk     (bus_clk),
    .rst_n_i     (rst_n_i),
    .cam_d_i     (cam_d_i),
    .cam_pclk_i  (cam_pclk_i),
    .cam_hsync_i (cam_hsync_i),
    .cam_vsync_i (cam_vsync_i),
    .cam_xclk_o  (cam_xclk_o),
    .pix_o       (pix),
    .hsync_o     (hsync),
    .vsync_o     (vsync),
    .pclk_rise_o (pclk_rise)
  );

  cam_word_packer u_word_packer (
    .bus_clk     (bus_clk),
    .rst_n_i     (rst_n_i),
    .rd32_open_i (rd32_open_i),
    .pix_i       (pix),
    .hsync_i     (hsync),
    .vsync_i     (vsync),
    .pclk_rise_i (pclk_rise),
    .word_o      (word),
    .word_stb_o  (word_stb)
  );

  cam_stream_fifo u_stream_fifo (
    .bus_clk      (bus_clk),
    .rst_n_i      (rst_n_i),
    .rd32_open_i  (rd32_open_i),
    .word_i       (word),
    .word_stb_i   (word_stb),
    .rd32_rden_i  (rd32_rden_i),
    .rd32_data_o  (rd32_data_o),
    .rd32_empty_o (rd32_empty_o),
    .rd32_eof_o   (rd32_eof_o)
  );

  // Register bank
  lite_addr_decode u_addr_decode (
    .bus_clk      (bus_clk),
    .rst_n_i      (rst_n_i),
    .lite_addr_i  (lite_addr_i),
    .lite_wren_i  (lite_wren_i),
    .lite_rden_i  (lite_rden_i),
    .lite_wstrb_i (lite_wstrb_i),
    .lane_idx_o   (lane_idx),
    .lane_we_o    (lane_we)
  );

  for (genvar g = 0; g < `GRB_BYTES_PER_WORD; g++)
  begin : g_lane
    lite_byte_lane u_byte_lane (
      .bus_clk    (bus_clk),
      .lane_idx_i (lane_idx),
      .lane_we_i  (lane_we[g]),
      .wr_byte_i  (lite_wr_data_i[g*`GRB_PIX_W +: `GRB_PIX_W]),
      .rd_byte_o  (lane_bytes[g])
    );
  end

  lite_read_capture u_read_capture (
    .bus_clk        (bus_clk),
    .rst_n_i        (rst_n_i),
    .lite_rden_i    (lite_rden_i),
    .lane_bytes_i   (lane_bytes),
    .lite_rd_data_o (lite_rd_data_o)
  );

endmodule

/* tb_grabber_top.sv */
`timescale 1ns/1ps
`include "grabber_settings.svh"

module tb_grabber_top import cam_pkg::*, lite_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int PCLK_HALF       = 4;
  localparam int WORD_CYCLES     = 2 * PCLK_HALF * `GRB_BYTES_PER_WORD;
  localparam int CAPTURE_WORDS   = 64;
  localparam int FULL_EXTRA      = 20;
  localparam int REG_WRITES      = 64;
  localparam int READ_WAIT       = 64;
  localparam int STREAM_WORDS    = 16 + CAPTURE_WORDS + `GRB_FIFO_DEPTH + FULL_EXTRA;
  localparam int WATCHDOG_CYCLES = 2 * STREAM_WORDS * WORD_CYCLES
                                   + 8 * (REG_WRITES + 2 * `GRB_LITE_WORDS) + 1000;
  localparam logic [31:0] SEED   = 32'hd8b7_c7e5;

  logic         bus_clk = 1'b0;
  logic         rst_n_i;
  pix_t         cam_d_i;
  logic         cam_pclk_i, cam_hsync_i, cam_vsync_i, cam_xclk_o;
  logic         rd32_open_i, rd32_rden_i, rd32_empty_o, rd32_eof_o;
  stream_word_t rd32_data_o;
  lite_addr_t   lite_addr_i;
  logic         lite_wren_i, lite_rden_i;
  lite_strb_t   lite_wstrb_i;
  lite_data_t   lite_wr_data_i, lite_rd_data_o;

  // Reference model of the stream and the register bank
  stream_word_t model_q[$];
  stream_word_t model_word;
  byte_pos_t    model_pos;
  logic         model_run, model_stop;
  lite_data_t   reg_model [`GRB_LITE_WORDS];

  logic [31:0]  rand_state;
  logic         xclk_armed, hold_empty, hold_eof;
  int           check_errs, prop_errs, tests_run, tests_failed;

  grabber_top u_grabber_top (.*);

  always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

  a_xclk_period: assert property (@(posedge bus_clk) disable iff (!rst_n_i)
    xclk_armed |-> (cam_xclk_o != $past(cam_xclk_o, 2)))
    else
    begin
      prop_errs++;
      $display("mismatch at %0d ns: sensor clock did not toggle every 2 cycles", $time);
    end

  a_hold_empty: assert property (@(posedge bus_clk) disable iff (!rst_n_i)
    hold_empty |-> rd32_empty_o)
    else
    begin
      prop_errs++;
      $display("mismatch at %0d ns: FIFO took a word before the frame started", $time);
    end

  a_eof_empty: assert property (@(posedge bus_clk) disable iff (!rst_n_i)
    rd32_eof_o |-> rd32_empty_o)
    else
    begin
      prop_errs++;
      $display("mismatch at %0d ns: eof high while the FIFO holds data", $time);
    end

  a_hold_eof: assert property (@(posedge bus_clk) disable iff (!rst_n_i)
    hold_eof |-> rd32_eof_o)
    else
    begin
      prop_errs++;
      $display("mismatch at %0d ns: eof dropped while the capture is stopped", $time);
    end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic void reset_model();
    model_q.delete();
    model_pos  = '0;
    model_run  = 1'b0;
    model_stop = 1'b0;
  endfunction

  // Frame starts on vsync and hsync bytes then fill words low byte first
  function automatic void model_byte(input pix_t d, input logic hs, input logic vs);
    if (!model_run)
      model_run = vs;
    else if (hs)
    begin
      model_word[model_pos*`GRB_PIX_W +: `GRB_PIX_W] = d;
      if (model_pos == byte_pos_t'(`GRB_BYTES_PER_WORD - 1) && !model_stop)
      begin
        model_q.push_back(model_word);
        // A full FIFO stops the capture until close
        if (model_q.size() == `GRB_FIFO_DEPTH)
          model_stop = 1'b1;
      end
      model_pos = model_pos + 1'b1;
    end
  endfunction

  task automatic step();
    @(posedge bus_clk);
    #2;
  endtask

  // One pixel period with data set up while pclk is low
  task automatic send_byte(input pix_t d, input logic hs, input logic vs);
    cam_d_i     = d;
    cam_hsync_i = hs;
    cam_vsync_i = vs;
    cam_pclk_i  = 1'b0;
    repeat (PCLK_HALF) step();
    cam_pclk_i  = 1'b1;
    repeat (PCLK_HALF) step();
    model_byte(d, hs, vs);
  endtask

  task automatic send_words(input int words, input logic gaps);
    for (int i = 0; i < words * `GRB_BYTES_PER_WORD; i++)
    begin
      // Blanking byte now and then
      if (gaps && (i % 16 == 15))
        send_byte(pix_t'(next_rand() >> 24), 1'b0, 1'b0);
      send_byte(pix_t'(next_rand() >> 16), 1'b1, 1'b0);
    end
  endtask

  // Line bytes ahead of vsync must be dropped
  task automatic frame_start_word(input int pre_bytes);
    hold_empty = 1'b1;
    repeat (pre_bytes) send_byte(pix_t'(next_rand() >> 16), 1'b1, 1'b0);
    send_byte(pix_t'(next_rand() >> 16), 1'b0, 1'b1);
    repeat (3) send_byte(pix_t'(next_rand() >> 16), 1'b1, 1'b0);
    hold_empty = 1'b0;
    send_byte(pix_t'(next_rand() >> 16), 1'b1, 1'b0);
  endtask

  task automatic read_word();
    stream_word_t exp;
    int           waited;
    exp    = model_q.pop_front();
    waited = 0;
    while (rd32_empty_o && waited < READ_WAIT)
    begin
      step();
      waited++;
    end
    if (rd32_empty_o)
    begin
      check_errs++;
      $display("Timed out at %0d ns waiting for a stored word", $time);
      return;
    end
    rd32_rden_i = 1'b1;
    step();
    rd32_rden_i = 1'b0;
    assert (rd32_data_o == exp)
    else
    begin
      check_errs++;
      $display("mismatch at %0d ns: stream word %h, expected %h", $time, rd32_data_o, exp);
    end
  endtask

  task automatic check_drained();
    stream_word_t held;
    assert (rd32_empty_o && model_q.size() == 0)
    else
    begin
      check_errs++;
      $display("FIFO still holds data at %0d ns after the expected words", $time);
    end
    // A read on the empty FIFO must leave data and flags alone
    if (rd32_empty_o)
    begin
      held        = rd32_data_o;
      rd32_rden_i = 1'b1;
      step();
      rd32_rden_i = 1'b0;
      assert (rd32_empty_o && rd32_data_o == held)
      else
      begin
        check_errs++;
        $display("mismatch at %0d ns: read on empty FIFO gave %h with empty=%b", $time,
                 rd32_data_o, rd32_empty_o);
      end
    end
  endtask

  task automatic close_stream();
    rd32_open_i = 1'b0;
    step();
    reset_model();
    assert (rd32_empty_o && !rd32_eof_o)
    else
    begin
      check_errs++;
      $display("mismatch at %0d ns: close left empty=%b eof=%b", $time, rd32_empty_o,
               rd32_eof_o);
    end
    rd32_open_i = 1'b1;
  endtask

  task automatic lite_write(input int idx, input lite_strb_t strb, input lite_data_t data);
    lite_addr_i    = lite_addr_t'(idx * 4);
    lite_wstrb_i   = strb;
    lite_wr_data_i = data;
    lite_wren_i    = 1'b1;
    for (int b = 0; b < `GRB_BYTES_PER_WORD; b++)
      if (strb[b])
        reg_model[idx][b*`GRB_PIX_W +: `GRB_PIX_W] = data[b*`GRB_PIX_W +: `GRB_PIX_W];
    step();
    lite_wren_i = 1'b0;
  endtask

  task automatic lite_read_check(input int idx);
    lite_addr_i = lite_addr_t'(idx * 4);
    lite_rden_i = 1'b1;
    step();
    lite_rden_i = 1'b0;
    // Read data must still hold one cycle on
    repeat (2)
    begin
      assert (lite_rd_data_o == reg_model[idx])
      else
      begin
        check_errs++;
        $display("mismatch at %0d ns: register %0d reads %h, expected %h", $time, idx,
                 lite_rd_data_o, reg_model[idx]);
      end
      step();
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = check_errs + prop_errs - errs_before;
    tests_run++;
    if (errs == 0)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  initial
  begin
    int mark;
    int idx;
    lite_strb_t strb;
    rst_n_i        = 1'b0;
    cam_d_i        = '0;
    cam_pclk_i     = 1'b0;
    cam_hsync_i    = 1'b0;
    cam_vsync_i    = 1'b0;
    rd32_open_i    = 1'b1;
    rd32_rden_i    = 1'b0;
    lite_addr_i    = '0;
    lite_wren_i    = 1'b0;
    lite_wstrb_i   = '0;
    lite_wr_data_i = '0;
    lite_rden_i    = 1'b0;
    rand_state     = SEED;
    xclk_armed     = 1'b0;
    hold_empty     = 1'b0;
    hold_eof       = 1'b0;
    check_errs     = 0;
    prop_errs      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    reset_model();

    mark = 0;
    repeat (4) step();
    assert (rd32_empty_o && !rd32_eof_o && lite_rd_data_o == '0)
    else
    begin
      check_errs++;
      $display("mismatch at %0d ns: outputs not idle in reset", $time);
    end
    rst_n_i = 1'b1;
    repeat (4) step();
    xclk_armed = 1'b1;
    repeat (16) step();
    xclk_armed = 1'b0;
    report_test("reset and sensor clock", mark);

    mark = check_errs + prop_errs;
    frame_start_word(6);
    read_word();
    check_drained();
    report_test("frame wait", mark);

    mark = check_errs + prop_errs;
    send_byte(pix_t'(next_rand() >> 16), 1'b0, 1'b1);
    send_words(CAPTURE_WORDS, 1'b1);
    while (model_q.size() > 0)
      read_word();
    check_drained();
    report_test("frame capture order", mark);

    mark = check_errs + prop_errs;
    send_words(`GRB_FIFO_DEPTH + FULL_EXTRA, 1'b0);
    assert (!rd32_empty_o && !rd32_eof_o)
    else
    begin
      check_errs++;
      $display("mismatch at %0d ns: full FIFO shows empty or eof", $time);
    end
    while (model_q.size() > 0)
      read_word();
    check_drained();
    // Capture stays stopped and drops more words
    hold_eof = 1'b1;
    send_words(2, 1'b0);
    repeat (4) step();
    check_drained();
    report_test("stop on full", mark);

    mark = check_errs + prop_errs;
    hold_eof = 1'b0;
    close_stream();
    send_byte(pix_t'(next_rand() >> 16), 1'b0, 1'b1);
    send_words(3, 1'b0);
    close_stream();
    frame_start_word(8);
    read_word();
    check_drained();
    report_test("close and reopen", mark);

    mark = check_errs + prop_errs;
    for (int i = 0; i < `GRB_LITE_WORDS; i++)
      lite_write(i, 4'hf, next_rand());
    for (int i = 0; i < REG_WRITES; i++)
    begin
      idx  = int'(next_rand() >> 27);
      strb = lite_strb_t'(next_rand() >> 28);
      lite_write(idx, strb, next_rand());
    end
    for (int i = 0; i < `GRB_LITE_WORDS; i++)
      lite_read_check(i);
    report_test("register bank", mark);

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             check_errs + prop_errs);
    if (tests_failed == 0 && check_errs + prop_errs == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // Bound on the whole run from the stream and register test lengths
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge bus_clk);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
cam_pkg.sv
lite_pkg.sv
cam_input_sync.sv
cam_word_packer.sv
cam_stream_fifo.sv
lite_addr_decode.sv
lite_byte_lane.sv
lite_read_capture.sv
grabber_top.sv
tb_grabber_top.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_grabber_top
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
	  echo "failure reported in $(LOG)"; exit 1; \
	elif ! grep -q "Simulation finished: PASS" $(LOG); then \
	  echo "no result line in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
